//--- design/tlbPkg.sv
`default_nettype none

package tlbPkg;

  // table geometry
  localparam int tlbEntryCount = 16;
  localparam int tlbIndexWidth = 4;

  // 4 KB pages, tag covers one even/odd page pair
  localparam int tlbPageBits = 12;
  localparam int tlbVpn2Width = 32 - tlbPageBits - 1;
  localparam int tlbPfnWidth = 24;

  // tag + two frames + dirty/valid per half
  localparam int tlbEntryWidth = tlbVpn2Width + 2 * (tlbPfnWidth + 2);

  // bits 70..0, same order as the software view
  typedef struct packed {
    logic [tlbVpn2Width-1:0] vpn2;
    logic [tlbPfnWidth-1:0] pfn1;
    logic dirty1;
    logic valid1;
    logic [tlbPfnWidth-1:0] pfn0;
    logic dirty0;
    logic valid0;
  } tlbEntryT;

  // entry 0 sits in the low bits
  typedef tlbEntryT [tlbEntryCount-1:0] tlbEntryArrayT;

  // one translation, 38 bits
  typedef struct packed {
    logic hit;
    logic [tlbIndexWidth-1:0] hitIndex;
    logic [31:0] physAddr;
    logic modFault;
  } tlbResultT;

endpackage

`default_nettype wire

//--- design/tlbLookupIf.sv
`default_nettype none
`timescale 1ns/1ps

interface tlbLookupIf;
  import tlbPkg::*;

  // strobe follows lookupValid in the same cycle
  logic resultValid;
  logic hit;
  logic [tlbIndexWidth-1:0] hitIndex;
  logic [31:0] physAddr;
  logic modFault;

  // fields gathered into one word for the response register
  tlbResultT payload;

  assign payload.hit = hit;
  assign payload.hitIndex = hitIndex;
  assign payload.physAddr = physAddr;
  assign payload.modFault = modFault;

  modport converter (
    output resultValid,
    output hit,
    output hitIndex,
    output physAddr,
    output modFault
  );

  modport response (
    input resultValid,
    input payload
  );

endinterface

`default_nettype wire

//--- design/tlbEntryArray.sv
`default_nettype none
`timescale 1ns/1ps

module tlbEntryArray (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             writeEn,
  input  logic [tlbPkg::tlbIndexWidth-1:0] writeIndex,
  input  tlbPkg::tlbEntryT                 writeEntry,
  output tlbPkg::tlbEntryArrayT            entries
);
  import tlbPkg::*;

  tlbEntryArrayT entryQ;

  // tags and frames survive reset, only the valid bits drop
  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < tlbEntryCount; i++) begin
        entryQ[i].valid0 <= 1'b0;
        entryQ[i].valid1 <= 1'b0;
      end
    end else if (writeEn) begin
      entryQ[writeIndex] <= writeEntry;
    end
  end

  // write lands at the edge, lookups see it next cycle
  assign entries = entryQ;

endmodule

`default_nettype wire

//--- design/tlbConverter.sv
`default_nettype none
`timescale 1ns/1ps

module tlbConverter (
  input  tlbPkg::tlbEntryArrayT entries,
  input  logic                  lookupValid,
  input  logic [31:0]           lookupAddr,
  input  logic                  lookupStore,
  tlbLookupIf.converter         result
);
  import tlbPkg::*;

  logic [tlbEntryCount-1:0] matched;
  logic [tlbIndexWidth-1:0] matchIndex;
  logic                     oddPage;
  tlbEntryT                 selEntry;
  logic [tlbPfnWidth-1:0]   selPfn;
  logic                     selDirty;
  logic                     anyHit;

  // bit 12 picks the half of the page pair
  assign oddPage = lookupAddr[tlbPageBits];

  // tag compare on every entry at once
  genvar i;
  generate
    for (i = 0; i < tlbEntryCount; i++) begin : gMatch
      assign matched[i] = (entries[i].vpn2 == lookupAddr[31:tlbPageBits+1]) &&
                          (oddPage ? entries[i].valid1 : entries[i].valid0);
    end
  endgenerate

  // lowest index wins, so scan from the top down
  always_comb begin
    matchIndex = '0;
    for (int j = tlbEntryCount - 1; j >= 0; j--) begin
      if (matched[j]) begin
        matchIndex = tlbIndexWidth'(j);
      end
    end
  end

  assign anyHit = |matched;
  assign selEntry = entries[matchIndex];

  // frame and dirty bit of the addressed half
  always_comb begin
    if (oddPage) begin
      selPfn = selEntry.pfn1;
      selDirty = selEntry.dirty1;
    end else begin
      selPfn = selEntry.pfn0;
      selDirty = selEntry.dirty0;
    end
  end

  assign result.resultValid = lookupValid;
  assign result.hit = anyHit;
  assign result.hitIndex = matchIndex;

  // upper frame bits beyond a 32-bit space are dropped
  assign result.physAddr = {selPfn[31-tlbPageBits:0], lookupAddr[tlbPageBits-1:0]};

  // store into a clean page
  assign result.modFault = anyHit && lookupStore && !selDirty;

endmodule

`default_nettype wire

//--- design/tlbResponse.sv
`default_nettype none
`timescale 1ns/1ps

module tlbResponse (
  input  logic                             clk,
  input  logic                             rstN,
  tlbLookupIf.response                     result,
  output logic                             respValid,
  output logic [31:0]                      physAddr,
  output logic                             miss,
  output logic                             modFault,
  output logic [tlbPkg::tlbIndexWidth-1:0] hitIndex
);
  import tlbPkg::*;

  tlbResultT payloadQ;

  // flags only mean something alongside respValid
  always_ff @(posedge clk) begin
    if (!rstN) begin
      respValid <= 1'b0;
      miss <= 1'b0;
      modFault <= 1'b0;
    end else begin
      respValid <= result.resultValid;
      miss <= result.resultValid && !result.payload.hit;
      modFault <= result.resultValid && result.payload.modFault;
    end
  end

  // address and index captured per lookup
  always_ff @(posedge clk) begin
    if (result.resultValid) begin
      payloadQ <= result.payload;
    end
  end

  assign physAddr = payloadQ.physAddr;
  assign hitIndex = payloadQ.hitIndex;

endmodule

`default_nettype wire

//--- design/tlbMmu.sv
`default_nettype none
`timescale 1ns/1ps

module tlbMmu (
  input  logic                             clk,
  input  logic                             rstN,
  // indexed write port
  input  logic                             writeEn,
  input  logic [tlbPkg::tlbIndexWidth-1:0] writeIndex,
  input  logic [tlbPkg::tlbEntryWidth-1:0] writeEntry,
  // lookup request
  input  logic                             lookupValid,
  input  logic [31:0]                      lookupAddr,
  input  logic                             lookupStore,
  // lookup response, one cycle later
  output logic                             respValid,
  output logic [31:0]                      physAddr,
  output logic                             miss,
  output logic                             modFault,
  output logic [tlbPkg::tlbIndexWidth-1:0] hitIndex
);
  import tlbPkg::*;

  tlbEntryArrayT entries;

  tlbLookupIf lookupBus ();

  tlbEntryArray uEntryArray (
    .clk        (clk),
    .rstN       (rstN),
    .writeEn    (writeEn),
    .writeIndex (writeIndex),
    .writeEntry (tlbEntryT'(writeEntry)),
    .entries    (entries)
  );

  tlbConverter uConverter (
    .entries     (entries),
    .lookupValid (lookupValid),
    .lookupAddr  (lookupAddr),
    .lookupStore (lookupStore),
    .result      (lookupBus.converter)
  );

  tlbResponse uResponse (
    .clk       (clk),
    .rstN      (rstN),
    .result    (lookupBus.response),
    .respValid (respValid),
    .physAddr  (physAddr),
    .miss      (miss),
    .modFault  (modFault),
    .hitIndex  (hitIndex)
  );

endmodule

`default_nettype wire

//--- sim/tlbMmuChecker.sv
`default_nettype none
`timescale 1ns/1ps

module tlbMmuChecker (
  input  logic              clk,
  input  logic              rstN,
  input  logic              lookupValid,
  input  logic [31:0]       lookupAddr,
  input  logic              lookupStore,
  input  logic [15:0][70:0] modelTable,
  input  logic              respValid,
  input  logic [31:0]       physAddr,
  input  logic              miss,
  input  logic              modFault,
  input  logic [3:0]        hitIndex,
  input  int                testNum,
  input  logic              allDone,
  output int                errorCount
);
  typedef struct packed {
    logic [31:0]       addr;
    logic              store;
    logic [15:0][70:0] snapshot;
  } lookupT;

  typedef struct packed {
    logic        hit;
    logic [3:0]  index;
    logic [31:0] physAddr;
    logic        modFault;
  } predictionT;

  lookupT pending[$];
  int passCount = 0;
  int failCount = 0;
  int testChecks = 0;
  int testErrors = 0;
  int lastTest = 0;
  logic doneSeen = 1'b0;

  assign errorCount = failCount;

  // entry bits: tag 70..52, odd half 51..26, even half 25..0
  function automatic predictionT predictTranslation(input logic [15:0][70:0] snapshot,
                                                    input logic [31:0] addr, input logic store);
    predictionT p;
    logic [23:0] pfn;
    logic dirty;
    logic valid;
    p = '0;
    for (int i = 0; i < 16; i++) begin
      pfn = addr[12] ? snapshot[i][51:28] : snapshot[i][25:2];
      dirty = addr[12] ? snapshot[i][27] : snapshot[i][1];
      valid = addr[12] ? snapshot[i][26] : snapshot[i][0];
      // first match from index 0 up is kept
      if (!p.hit && valid && snapshot[i][70:52] == addr[31:13]) begin
        p.hit = 1'b1;
        p.index = 4'(i);
        p.physAddr = {pfn[19:0], addr[11:0]};
        p.modFault = store && !dirty;
      end
    end
    return p;
  endfunction

  task automatic compareField(input string name, input logic [31:0] want, input logic [31:0] got);
    testChecks++;
    if (want !== got) begin
      testErrors++;
      failCount++;
      $display("FAILED at %0t: %s expected 0x%0h, DUT 0x%0h", $time, name, want, got);
    end else begin
      passCount++;
    end
  endtask

  task automatic reportError(input string text);
    testErrors++;
    failCount++;
    $display("error at %0t: %s", $time, text);
  endtask

  always @(posedge clk) begin
    lookupT cur;
    predictionT want;
    if (!rstN) begin
      pending.delete();
    end else begin
      if (respValid) begin
        if (pending.size() == 0) begin
          reportError("respValid came with no lookup outstanding");
        end else begin
          cur = pending.pop_front();
          want = predictTranslation(cur.snapshot, cur.addr, cur.store);
          compareField("miss", 32'(!want.hit), 32'(miss));
          compareField("modFault", 32'(want.modFault), 32'(modFault));
          if (want.hit) begin
            compareField("hitIndex", 32'(want.index), 32'(hitIndex));
            compareField("physAddr", want.physAddr, physAddr);
          end
        end
      end else if (pending.size() != 0) begin
        reportError("a lookup got no response one cycle after it was issued");
        pending.delete();
      end
      // snapshot holds the table before this edge's write
      if (lookupValid) begin
        cur = {lookupAddr, lookupStore, modelTable};
        pending.push_back(cur);
      end
    end
    if (testNum != lastTest || (allDone && !doneSeen)) begin
      if (lastTest != 0) begin
        $display("test %0d done: %0d checks, %0d errors", lastTest, testChecks, testErrors);
      end
      testChecks = 0;
      testErrors = 0;
      lastTest = testNum;
    end
    if (allDone && !doneSeen) begin
      doneSeen = 1'b1;
      $display("checks passed: %0d, checks failed: %0d", passCount, failCount);
    end
  end

endmodule

`default_nettype wire

//--- sim/tlbMmu_assert.sv
`default_nettype none
`timescale 1ns/1ps

module tlbMmuAssert (
  input logic clk,
  input logic rstN,
  input logic lookupValid,
  input logic respValid,
  input logic miss,
  input logic modFault
);
  // response strobe is the request strobe one cycle late
  respAfterLookup: assert property (@(posedge clk) (rstN && lookupValid) |=> respValid)
    else $error("respValid missing one cycle after lookupValid");
  noExtraResp: assert property (@(posedge clk) (rstN && !lookupValid) |=> !respValid)
    else $error("respValid high without a lookup one cycle before");

  missNotFault: assert property (@(posedge clk) disable iff (!rstN) !(miss && modFault))
    else $error("miss and modFault high together");

  quietAfterReset: assert property (@(posedge clk) !rstN |=> (!respValid && !miss && !modFault))
    else $error("control outputs not low after reset");
endmodule

bind tlbMmu tlbMmuAssert assert0 (
  .clk         (clk),
  .rstN        (rstN),
  .lookupValid (lookupValid),
  .respValid   (respValid),
  .miss        (miss),
  .modFault    (modFault)
);

`default_nettype wire

//--- sim/tlbMmuTb.sv
`default_nettype none
`timescale 1ns/1ps

module tlbMmuTb;
  localparam int resetCycles = 2;
  // start, lookups and drain of tests 1 to 5
  localparam int directedCycles = 9 + 15 + 8 + 9 + 7;
  localparam int randomCycles = 300;
  localparam int cycleLimit = 4 * (resetCycles + directedCycles + randomCycles + 6) + 100;

  logic clk, rstN, writeEn, lookupValid, lookupStore;
  logic [3:0] writeIndex;
  logic [70:0] writeEntry;
  logic [31:0] lookupAddr;
  logic respValid, miss, modFault;
  logic [31:0] physAddr;
  logic [3:0] hitIndex;
  logic [15:0][70:0] modelTable;
  logic [18:0] tagPool [4];
  logic allDone;
  int testNum, errorCount, seed, cycleCount;

  tlbMmu dut0 (
    .clk(clk), .rstN(rstN), .writeEn(writeEn), .writeIndex(writeIndex),
    .writeEntry(writeEntry), .lookupValid(lookupValid), .lookupAddr(lookupAddr),
    .lookupStore(lookupStore), .respValid(respValid), .physAddr(physAddr),
    .miss(miss), .modFault(modFault), .hitIndex(hitIndex)
  );

  tlbMmuChecker checker0 (
    .clk(clk), .rstN(rstN), .lookupValid(lookupValid), .lookupAddr(lookupAddr),
    .lookupStore(lookupStore), .modelTable(modelTable), .respValid(respValid),
    .physAddr(physAddr), .miss(miss), .modFault(modFault), .hitIndex(hitIndex),
    .testNum(testNum), .allDone(allDone), .errorCount(errorCount)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // model table follows the DUT write port edge for edge
  always @(posedge clk) begin
    if (!rstN) begin
      modelTable <= '0;
    end else if (writeEn) begin
      modelTable[writeIndex] <= writeEntry;
    end
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout: run still going after %0d cycles", cycleLimit);
    $display("Test failed");
    $finish;
  end

  function automatic logic [70:0] makeEntry(input logic [18:0] tag, input logic [23:0] pfn1,
      input logic dirty1, input logic valid1, input logic [23:0] pfn0, input logic dirty0,
      input logic valid0);
    return {tag, pfn1, dirty1, valid1, pfn0, dirty0, valid0};
  endfunction

  function automatic logic [31:0] pageAddr(input logic [18:0] tag, input logic odd,
                                           input logic [11:0] offset);
    return {tag, odd, offset};
  endfunction

  task automatic driveCycle(input logic we, input logic [3:0] idx, input logic [70:0] entry,
                            input logic lv, input logic [31:0] addr, input logic store);
    @(posedge clk);
    writeEn <= we;
    writeIndex <= idx;
    writeEntry <= entry;
    lookupValid <= lv;
    lookupAddr <= addr;
    lookupStore <= store;
  endtask

  task automatic issueWrite(input logic [3:0] idx, input logic [70:0] entry);
    driveCycle(1'b1, idx, entry, 1'b0, 32'h0, 1'b0);
  endtask

  task automatic issueLookup(input logic [31:0] addr, input logic store);
    driveCycle(1'b0, 4'h0, 71'h0, 1'b1, addr, store);
  endtask

  task automatic idleCycles(input int n);
    repeat (n) driveCycle(1'b0, 4'h0, 71'h0, 1'b0, 32'h0, 1'b0);
  endtask

  task automatic startTest(input int n);
    @(posedge clk);
    testNum <= n;
  endtask

  task automatic runDirected();
    logic [31:0] r;
    logic [18:0] tag;
    // empty table after reset
    startTest(1);
    repeat (6) begin
      r = $random(seed);
      issueLookup(r, r[5]);
    end
    idleCycles(2);
    // both halves valid and dirty
    startTest(2);
    for (int i = 0; i < 4; i++) begin
      r = $random(seed);
      issueWrite(4'(i), makeEntry(19'h01000 + 19'(i), r[23:0], 1'b1, 1'b1, ~r[23:0], 1'b1, 1'b1));
    end
    for (int i = 0; i < 4; i++) begin
      r = $random(seed);
      issueLookup(pageAddr(19'h01000 + 19'(i), 1'b0, r[11:0]), 1'b0);
      issueLookup(pageAddr(19'h01000 + 19'(i), 1'b1, r[23:12]), 1'b1);
    end
    idleCycles(2);
    // odd half invalid, then write and lookup in one cycle
    startTest(3);
    tag = 19'h2abcd;
    issueWrite(4'd5, makeEntry(tag, 24'h0000aa, 1'b1, 1'b0, 24'h000bb1, 1'b1, 1'b1));
    issueLookup(pageAddr(tag, 1'b1, 12'h123), 1'b0);
    issueLookup(pageAddr(tag, 1'b0, 12'h456), 1'b0);
    driveCycle(1'b1, 4'd5, makeEntry(tag, 24'h0000cc, 1'b1, 1'b1, 24'h000bb1, 1'b1, 1'b1),
               1'b1, pageAddr(tag, 1'b1, 12'h789), 1'b0);
    issueLookup(pageAddr(tag, 1'b1, 12'h789), 1'b0);
    idleCycles(2);
    // duplicate tag in entries 7 and 9
    startTest(4);
    tag = 19'h33333;
    issueWrite(4'd9, makeEntry(tag, 24'h000901, 1'b1, 1'b1, 24'h000900, 1'b1, 1'b1));
    issueWrite(4'd7, makeEntry(tag, 24'h000701, 1'b1, 1'b1, 24'h000700, 1'b1, 1'b1));
    issueLookup(pageAddr(tag, 1'b0, 12'h0ff), 1'b0);
    issueWrite(4'd7, makeEntry(19'h44444, 24'h000701, 1'b1, 1'b1, 24'h000700, 1'b1, 1'b1));
    issueLookup(pageAddr(tag, 1'b1, 12'h0ff), 1'b0);
    issueLookup(pageAddr(19'h44444, 1'b0, 12'h0ff), 1'b0);
    idleCycles(2);
    // clean even half, dirty odd half
    startTest(5);
    tag = 19'h55555;
    issueWrite(4'd10, makeEntry(tag, 24'h000a01, 1'b1, 1'b1, 24'h000a00, 1'b0, 1'b1));
    issueLookup(pageAddr(tag, 1'b0, 12'h010), 1'b1);
    issueLookup(pageAddr(tag, 1'b1, 12'h010), 1'b1);
    issueLookup(pageAddr(tag, 1'b0, 12'h010), 1'b0);
    idleCycles(2);
  endtask

  task automatic runRandomMix();
    logic [31:0] r;
    logic [31:0] f;
    startTest(6);
    repeat (randomCycles) begin
      r = $random(seed);
      f = $random(seed);
      driveCycle(r[1:0] == 2'b00, r[5:2],
                 makeEntry(tagPool[r[7:6]], f[23:0], r[8], r[9], {f[31:24], f[15:0]}, r[10], r[11]),
                 r[13:12] != 2'b00, pageAddr(tagPool[r[15:14]], r[16], f[27:16]), r[17]);
    end
    idleCycles(2);
  endtask

  initial begin
    seed = 12;
    rstN = 1'b0;
    writeEn = 1'b0;
    writeIndex = 4'h0;
    writeEntry = 71'h0;
    lookupValid = 1'b0;
    lookupAddr = 32'h0;
    lookupStore = 1'b0;
    testNum = 0;
    allDone = 1'b0;
    tagPool[0] = 19'h00100;
    tagPool[1] = 19'h00101;
    tagPool[2] = 19'h7f0a3;
    tagPool[3] = 19'h12345;
    repeat (resetCycles) @(posedge clk);
    rstN <= 1'b1;
    runDirected();
    runRandomMix();
    @(posedge clk);
    allDone <= 1'b1;
    repeat (2) @(posedge clk);
    if (errorCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tlbMmu.f
design/tlbPkg.sv
design/tlbLookupIf.sv
design/tlbEntryArray.sv
design/tlbConverter.sv
design/tlbResponse.sv
design/tlbMmu.sv
sim/tlbMmuChecker.sv
sim/tlbMmu_assert.sv
sim/tlbMmuTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tlbMmu.f --top-module tlbMmuTb -o tlbMmuSim
if [ $? -ne 0 ]; then
  echo "compile with Verilator failed"
  exit 1
fi

./obj_dir/tlbMmuSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0
